// File: filelist.f
+incdir+include
rtl/decode_pkg.sv
rtl/control_decoder.sv
rtl/imm_generator.sv
rtl/branch_unit.sv
rtl/decode_output_reg.sv
rtl/decode_stage.sv
testbench/tb_decode_stage.sv

// File: rtl/branch_unit.sv
/*
 * Branch resolution
 * Operand bypass select, compare, and taken and target for COND, JAL and JALR
 */
`timescale 1ns/10ps
`default_nettype none

module branch_unit
    import decode_pkg::*;
(
    input  pc_word_t i_pc_word,
    input  logic     i_valid,
    input  branch_e  i_branch,
    input  cmp_op_e  i_cmp_op,
    input  word_t    i_offset,
    input  word_t    i_rs1_rdata,
    input  word_t    i_rs2_rdata,
    input  bypass_s  i_bypass,
    output word_t    o_rs1_data,
    output word_t    o_rs2_data,
    output branch_s  o_branch
);
    logic  cmp_true;
    word_t jalr_sum; // Full sum, LSBs dropped afterwards

    always_comb begin
        o_rs1_data = i_bypass.rs1_en ? i_bypass.rs1_data : i_rs1_rdata; // Forwarded wins
        o_rs2_data = i_bypass.rs2_en ? i_bypass.rs2_data : i_rs2_rdata;
    end

    always_comb begin
        case (i_cmp_op)
            CMP_OP_BEQ:  cmp_true = (o_rs1_data == o_rs2_data);
            CMP_OP_BNE:  cmp_true = (o_rs1_data != o_rs2_data);
            CMP_OP_BLT:  cmp_true = ($signed(o_rs1_data) < $signed(o_rs2_data));
            CMP_OP_BGE:  cmp_true = ($signed(o_rs1_data) >= $signed(o_rs2_data));
            CMP_OP_BLTU: cmp_true = (o_rs1_data < o_rs2_data);
            CMP_OP_BGEU: cmp_true = (o_rs1_data >= o_rs2_data);
            default:     cmp_true = 1'b0; // Reserved funct3
        endcase
    end

    always_comb begin
        jalr_sum = o_rs1_data + i_offset; // Carry out of bits 1:0 reaches the target
        case (i_branch)
            BRANCH_COND: begin
                o_branch.taken  = i_valid & cmp_true;
                o_branch.target = i_pc_word + i_offset[XLEN-1:2];
            end
            BRANCH_JAL: begin
                o_branch.taken  = i_valid;
                o_branch.target = i_pc_word + i_offset[XLEN-1:2];
            end
            BRANCH_JALR: begin
                o_branch.taken  = i_valid;
                o_branch.target = jalr_sum[XLEN-1:2];
            end
            default: begin
                o_branch.taken  = 1'b0;
                o_branch.target = '0;
            end
        endcase
    end
endmodule : branch_unit

`default_nettype wire

// File: rtl/control_decoder.sv
/*
 * Opcode decoder
 * Maps the instruction word to its format and the control word for execute
 */
`timescale 1ns/10ps
`default_nettype none

module control_decoder
    import decode_pkg::*;
(
    input  word_t i_instr,
    output ctrl_s o_ctrl
);
    opcode_e    opcode;
    logic [2:0] funct3;
    logic       funct7_b5; // instr[30], SUB and SRA select

    // Common to OP and OP_IMM
    function automatic alu_op_e alu_op_from(input logic [2:0] f3, input logic alt,
                                            input logic allow_sub);
        case (f3)
            3'b000:  return (alt && allow_sub) ? ALU_OP_SUB : ALU_OP_ADD;
            3'b001:  return ALU_OP_SLL;
            3'b010:  return ALU_OP_SLT;
            3'b011:  return ALU_OP_SLTU;
            3'b100:  return ALU_OP_XOR;
            3'b101:  return alt ? ALU_OP_SRA : ALU_OP_SRL;
            3'b110:  return ALU_OP_OR;
            default: return ALU_OP_AND;
        endcase
    endfunction

    always_comb begin
        opcode    = opcode_e'(i_instr[6:2]);
        funct3    = i_instr[14:12];
        funct7_b5 = i_instr[30];
        o_ctrl    = '0; // Zero fields mean RS1/RS2/ALU/no memory/no branch
        case (opcode)
            OPCODE_OP: begin
                o_ctrl.instr_format = INSTR_FORMAT_R;
                o_ctrl.rd_we        = 1'b1;
                o_ctrl.alu_op       = alu_op_from(funct3, funct7_b5, 1'b1);
            end
            OPCODE_OP_IMM: begin
                o_ctrl.instr_format = INSTR_FORMAT_I;
                o_ctrl.rd_we        = 1'b1;
                o_ctrl.alu_op2_src  = ALU_OP2_SRC_IMM;
                o_ctrl.alu_op       = alu_op_from(funct3, funct7_b5, 1'b0); // No SUBI
            end
            OPCODE_LOAD: begin
                o_ctrl.instr_format  = INSTR_FORMAT_I;
                o_ctrl.rd_src        = RD_SRC_MEM;
                o_ctrl.rd_we         = 1'b1;
                o_ctrl.alu_op2_src   = ALU_OP2_SRC_IMM; // Address is rs1 + imm
                o_ctrl.memory_op     = MEM_OP_LOAD;
                o_ctrl.memory_signed = ~funct3[2];      // LBU/LHU clear it
                o_ctrl.memory_size   = size_e'(funct3[1:0]);
            end
            OPCODE_STORE: begin
                o_ctrl.instr_format  = INSTR_FORMAT_S;
                o_ctrl.alu_op2_src   = ALU_OP2_SRC_IMM;
                o_ctrl.memory_op     = MEM_OP_STORE;
                o_ctrl.memory_signed = ~funct3[2];
                o_ctrl.memory_size   = size_e'(funct3[1:0]);
            end
            OPCODE_LUI: begin
                o_ctrl.instr_format = INSTR_FORMAT_U;
                o_ctrl.rd_we        = 1'b1;
                o_ctrl.alu_op1_src  = ALU_OP1_SRC_ZERO; // 0 + imm
                o_ctrl.alu_op2_src  = ALU_OP2_SRC_IMM;
            end
            OPCODE_AUIPC: begin
                o_ctrl.instr_format = INSTR_FORMAT_U;
                o_ctrl.rd_we        = 1'b1;
                o_ctrl.alu_op1_src  = ALU_OP1_SRC_PC;
                o_ctrl.alu_op2_src  = ALU_OP2_SRC_IMM;
            end
            OPCODE_JAL: begin
                o_ctrl.instr_format = INSTR_FORMAT_J;
                o_ctrl.rd_we        = 1'b1;
                o_ctrl.alu_op1_src  = ALU_OP1_SRC_PC;
                o_ctrl.alu_op2_src  = ALU_OP2_SRC_IMM;
                o_ctrl.branch       = BRANCH_JAL;
            end
            OPCODE_JALR: begin
                o_ctrl.instr_format = INSTR_FORMAT_I;
                o_ctrl.rd_we        = 1'b1;
                o_ctrl.alu_op1_src  = ALU_OP1_SRC_PC;   // Link is pc + 4
                o_ctrl.alu_op2_src  = ALU_OP2_SRC_FOUR;
                o_ctrl.branch       = BRANCH_JALR;
            end
            OPCODE_BRANCH: begin
                o_ctrl.instr_format       = INSTR_FORMAT_B;
                o_ctrl.branch             = BRANCH_COND;
                o_ctrl.cond_branch_cmp_op = cmp_op_e'(funct3);
            end
            OPCODE_MISC_MEM: begin
                o_ctrl.instr_format = INSTR_FORMAT_I;
                o_ctrl.fence        = 1'b1; // FENCE and FENCE.I alike
            end
            default: begin // SYSTEM and everything unknown
                o_ctrl.illegal_instr = 1'b1;
                o_ctrl.instr_format  = INSTR_FORMAT_BAD;
            end
        endcase
    end
endmodule : control_decoder

`default_nettype wire

// File: rtl/decode_output_reg.sv
/*
 * Decode to execute pipeline register
 * Valid has reset and flush, stall holds every field
 */
`timescale 1ns/10ps
`default_nettype none

module decode_output_reg
    import decode_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_stage_stall,
    input  logic     i_stage_flush,
    input  f2_to_d_s i_f2_to_d,
    input  ctrl_s    i_ctrl,
    input  word_t    i_imm,
    input  word_t    i_rs1_data,
    input  word_t    i_rs2_data,
    output d_to_e1_s o_d_to_e1
);
    d_to_e1_s next_rec;

    always_comb begin
        next_rec.valid         = i_f2_to_d.valid;
        next_rec.pc_word       = i_f2_to_d.pc_word;
        next_rec.illegal_instr = i_ctrl.illegal_instr;
        next_rec.rd_src        = i_ctrl.rd_src;
        next_rec.rd_idx        = i_f2_to_d.instr[11:7];
        next_rec.rd_we         = i_ctrl.rd_we;
        next_rec.rs1_idx       = i_f2_to_d.instr[19:15];
        next_rec.rs2_idx       = i_f2_to_d.instr[24:20];
        next_rec.rs1_rdata     = i_rs1_data;         // Already bypass selected
        next_rec.rs2_rdata     = i_rs2_data;
        next_rec.immediate     = i_imm;
        next_rec.alu_op1_src   = i_ctrl.alu_op1_src;
        next_rec.alu_op2_src   = i_ctrl.alu_op2_src;
        next_rec.alu_op        = i_ctrl.alu_op;
        next_rec.memory_op     = i_ctrl.memory_op;
        next_rec.memory_signed = i_ctrl.memory_signed;
        next_rec.memory_size   = i_ctrl.memory_size;
        next_rec.fence         = i_ctrl.fence;
    end

    always_ff @(posedge i_clk) begin
        if (!i_stage_stall) begin
            o_d_to_e1 <= next_rec;       // Whole record, valid included
        end
        if (!i_rst_n || i_stage_flush) begin
            o_d_to_e1.valid <= 1'b0;     // Overrides the load above
        end
    end

    // Hazard unit contract
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_stage_stall && i_stage_flush));

    // Nothing reaches execute straight out of reset
    assert property (@(posedge i_clk) !i_rst_n |=> !o_d_to_e1.valid);
endmodule : decode_output_reg

`default_nettype wire

// File: rtl/decode_pkg.sv
/*
 * Decode stage package
 * Widths, opcode and control encodings, and the structs passed between stages
 */
`default_nettype none

package decode_pkg;
    localparam int XLEN      = 32;
    localparam int PC_WORD_W = 30; // PC without the two zero LSBs
    localparam int REG_IDX_W = 5;

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [PC_WORD_W-1:0] pc_word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // Major opcode, instr[6:2]
    typedef enum logic [4:0] {
        OPCODE_LOAD     = 5'b00000,
        OPCODE_LOAD_FP  = 5'b00001,
        OPCODE_MISC_MEM = 5'b00011,
        OPCODE_OP_IMM   = 5'b00100,
        OPCODE_AUIPC    = 5'b00101,
        OPCODE_STORE    = 5'b01000,
        OPCODE_STORE_FP = 5'b01001,
        OPCODE_AMO      = 5'b01011,
        OPCODE_OP       = 5'b01100,
        OPCODE_LUI      = 5'b01101,
        OPCODE_OP_FP    = 5'b10100,
        OPCODE_BRANCH   = 5'b11000,
        OPCODE_JALR     = 5'b11001,
        OPCODE_JAL      = 5'b11011,
        OPCODE_SYSTEM   = 5'b11100  // Not supported, decodes as illegal
    } opcode_e;

    typedef enum logic [2:0] {
        INSTR_FORMAT_BAD = 3'b000,
        INSTR_FORMAT_R,
        INSTR_FORMAT_I,
        INSTR_FORMAT_S,
        INSTR_FORMAT_B,
        INSTR_FORMAT_U,
        INSTR_FORMAT_J
    } instr_format_e;

    typedef enum logic [1:0] {BRANCH_NONE, BRANCH_COND, BRANCH_JALR, BRANCH_JAL} branch_e;

    // Same encoding as branch funct3, 010 and 011 unused
    typedef enum logic [2:0] {
        CMP_OP_BEQ  = 3'b000,
        CMP_OP_BNE  = 3'b001,
        CMP_OP_BLT  = 3'b100,
        CMP_OP_BGE  = 3'b101,
        CMP_OP_BLTU = 3'b110,
        CMP_OP_BGEU = 3'b111
    } cmp_op_e;

    typedef enum logic [3:0] {
        ALU_OP_ADD, ALU_OP_SUB, ALU_OP_SLL, ALU_OP_SLT, ALU_OP_SLTU,
        ALU_OP_XOR, ALU_OP_SRL, ALU_OP_SRA, ALU_OP_OR, ALU_OP_AND
    } alu_op_e;

    typedef enum logic [1:0] {ALU_OP1_SRC_RS1, ALU_OP1_SRC_PC, ALU_OP1_SRC_ZERO} alu_op1_src_e;
    typedef enum logic [1:0] {ALU_OP2_SRC_RS2, ALU_OP2_SRC_IMM, ALU_OP2_SRC_FOUR} alu_op2_src_e;
    typedef enum logic       {RD_SRC_ALU, RD_SRC_MEM} rd_src_e;
    typedef enum logic [1:0] {MEM_OP_NONE, MEM_OP_LOAD, MEM_OP_STORE} mem_op_e;
    typedef enum logic [1:0] {SIZE_BYTE, SIZE_HALF, SIZE_WORD} size_e; // funct3[1:0]

    // Control word from the opcode decoder
    typedef struct packed {
        logic          illegal_instr;
        instr_format_e instr_format;
        rd_src_e       rd_src;
        logic          rd_we;
        alu_op1_src_e  alu_op1_src;
        alu_op2_src_e  alu_op2_src;
        alu_op_e       alu_op;
        mem_op_e       memory_op;
        logic          memory_signed;
        size_e         memory_size;
        branch_e       branch;
        cmp_op_e       cond_branch_cmp_op;
        logic          fence;
    } ctrl_s;

    typedef struct packed {
        logic     valid;   // Qualifies the rest
        pc_word_t pc_word;
        word_t    instr;
    } f2_to_d_s;

    typedef struct packed {
        logic  rs1_en;     // Replace RF rs1 data
        logic  rs2_en;
        word_t rs1_data;
        word_t rs2_data;
    } bypass_s;

    typedef struct packed {
        logic     taken;
        pc_word_t target;
    } branch_s;

    typedef struct packed {
        logic         valid;
        pc_word_t     pc_word;
        logic         illegal_instr;
        rd_src_e      rd_src;
        reg_idx_t     rd_idx;
        logic         rd_we;
        reg_idx_t     rs1_idx;
        reg_idx_t     rs2_idx;
        word_t        rs1_rdata;
        word_t        rs2_rdata;
        word_t        immediate;
        alu_op1_src_e alu_op1_src;
        alu_op2_src_e alu_op2_src;
        alu_op_e      alu_op;
        mem_op_e      memory_op;
        logic         memory_signed;
        size_e        memory_size;
        logic         fence;
    } d_to_e1_s;
endpackage : decode_pkg

`default_nettype wire

// File: rtl/decode_stage.sv
/*
 * RV32I decode stage
 * Opcode decode, immediates, register read, branch resolution, execute register
 */
`timescale 1ns/10ps
`default_nettype none

module decode_stage
    import decode_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_stage_flush,
    input  logic     i_stage_stall,
    input  f2_to_d_s i_f2_to_d,
    output reg_idx_t o_rs1_idx,
    output reg_idx_t o_rs2_idx,
    input  word_t    i_rs1_rdata,
    input  word_t    i_rs2_rdata,
    input  bypass_s  i_bypass,
    output branch_s  o_branch,
    output d_to_e1_s o_d_to_e1
);
    ctrl_s ctrl;
    word_t imm;
    word_t branch_offset;
    word_t rs1_data;
    word_t rs2_data;

    // RF read address, answered in the same cycle
    assign o_rs1_idx = i_f2_to_d.instr[19:15];
    assign o_rs2_idx = i_f2_to_d.instr[24:20];

    control_decoder ctrl_dec_i (
        .i_instr (i_f2_to_d.instr),
        .o_ctrl  (ctrl)
    );

    imm_generator imm_gen_i (
        .i_instr         (i_f2_to_d.instr),
        .i_format        (ctrl.instr_format),
        .o_imm           (imm),
        .o_branch_offset (branch_offset)
    );

    branch_unit branch_i (
        .i_pc_word   (i_f2_to_d.pc_word),
        .i_valid     (i_f2_to_d.valid),
        .i_branch    (ctrl.branch),
        .i_cmp_op    (ctrl.cond_branch_cmp_op),
        .i_offset    (branch_offset),
        .i_rs1_rdata (i_rs1_rdata),
        .i_rs2_rdata (i_rs2_rdata),
        .i_bypass    (i_bypass),
        .o_rs1_data  (rs1_data),
        .o_rs2_data  (rs2_data),
        .o_branch    (o_branch)       // Combinational to fetch
    );

    decode_output_reg out_reg_i (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_stage_stall (i_stage_stall),
        .i_stage_flush (i_stage_flush),
        .i_f2_to_d     (i_f2_to_d),
        .i_ctrl        (ctrl),
        .i_imm         (imm),
        .i_rs1_data    (rs1_data),
        .i_rs2_data    (rs2_data),
        .o_d_to_e1     (o_d_to_e1)
    );
endmodule : decode_stage

`default_nettype wire

// File: rtl/imm_generator.sv
/*
 * Immediate generator
 * Sign-extended immediate for execute and the offset for branch resolution
 */
`timescale 1ns/10ps
`default_nettype none

module imm_generator
    import decode_pkg::*;
(
    input  word_t         i_instr,
    input  instr_format_e i_format,
    output word_t         o_imm,
    output word_t         o_branch_offset
);
    word_t imm_i, imm_s, imm_b, imm_u, imm_j;

    always_comb begin
        imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
        imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
        imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                 i_instr[11:8], 1'b0};
        imm_u = {i_instr[31:12], 12'h000};                      // Low bits always zero
        imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                 i_instr[30:21], 1'b0};
    end

    // Execute only sees I, S and U
    always_comb begin
        case (i_format)
            INSTR_FORMAT_I: o_imm = imm_i;
            INSTR_FORMAT_S: o_imm = imm_s;
            INSTR_FORMAT_U: o_imm = imm_u;
            default:        o_imm = '0;
        endcase
    end

    always_comb begin
        case (i_format)
            INSTR_FORMAT_B: o_branch_offset = imm_b;
            INSTR_FORMAT_J: o_branch_offset = imm_j;
            INSTR_FORMAT_I: o_branch_offset = imm_i; // JALR
            default:        o_branch_offset = '0;
        endcase
    end
endmodule : imm_generator

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f \
    --top-module tb_decode_stage -o tb_decode_stage

status=0
./obj_dir/tb_decode_stage > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Test failed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation PASSED"

// File: include/tb_decode_model.svh
/*
 * Decode stage reference model
 * Instruction encoders and expected control, immediate and branch results
 */
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2, input reg_idx_t rs1,
                                input logic [2:0] f3, input reg_idx_t rd, input opcode_e op);
    return {f7, rs2, rs1, f3, rd, op, 2'b11};
endfunction

function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                input logic [2:0] f3, input reg_idx_t rd, input opcode_e op);
    return {imm, rs1, f3, rd, op, 2'b11};
endfunction

function automatic word_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                input reg_idx_t rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPCODE_STORE, 2'b11};
endfunction

// Bit 0 of the offset is not encoded
function automatic word_t enc_b(input logic [12:0] imm, input reg_idx_t rs2,
                                input reg_idx_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPCODE_BRANCH, 2'b11};
endfunction

function automatic word_t enc_u(input logic [19:0] imm, input reg_idx_t rd, input opcode_e op);
    return {imm, rd, op, 2'b11};
endfunction

function automatic word_t enc_j(input logic [20:0] imm, input reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPCODE_JAL, 2'b11};
endfunction

// Execute immediate by opcode
function automatic word_t model_imm(input word_t instr);
    case (instr[6:2])
        OPCODE_LOAD, OPCODE_OP_IMM, OPCODE_JALR, OPCODE_MISC_MEM:
            return {{20{instr[31]}}, instr[31:20]};
        OPCODE_STORE:              return {{20{instr[31]}}, instr[31:25], instr[11:7]};
        OPCODE_LUI, OPCODE_AUIPC:  return {instr[31:12], 12'h000};
        default:                   return '0;
    endcase
endfunction

// Offset seen by the branch logic
function automatic word_t model_offset(input word_t instr);
    case (instr[6:2])
        OPCODE_BRANCH: return {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        OPCODE_JAL:    return {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        OPCODE_JALR:   return {{20{instr[31]}}, instr[31:20]};
        default:       return '0;
    endcase
endfunction

function automatic logic model_cmp(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
        3'b000:  return a == b;
        3'b001:  return a != b;
        3'b100:  return $signed(a) < $signed(b);
        3'b101:  return $signed(a) >= $signed(b);
        3'b110:  return a < b;
        3'b111:  return a >= b;
        default: return 1'b0;
    endcase
endfunction

// Taken and target for one input, operands already bypass selected
function automatic branch_s model_branch(input word_t instr, input logic valid,
                                         input pc_word_t pc, input word_t rs1, input word_t rs2);
    branch_s br;
    word_t   off;
    word_t   sum;
    br  = '0;
    off = model_offset(instr);
    sum = rs1 + off;
    case (instr[6:2])
        OPCODE_BRANCH: begin
            br.taken  = valid && model_cmp(instr[14:12], rs1, rs2);
            br.target = pc + off[31:2];
        end
        OPCODE_JAL: begin
            br.taken  = valid;
            br.target = pc + off[31:2];
        end
        OPCODE_JALR: begin
            br.taken  = valid;
            br.target = sum[31:2];
        end
        default: br = '0;
    endcase
    return br;
endfunction

`endif

// File: testbench/tb_decode_stage.sv
/*
 * Decode stage testbench
 * Seeded random RV32I traffic with stall, flush and bypass, checked against a model
 */
`timescale 1ns/10ps
`default_nettype none

module tb_decode_stage
    import decode_pkg::*;
();
    localparam int NUM_CYCLES  = 600;
    localparam int IDLE_CYCLES = 4;
    localparam int WAIT_MAX    = 20; // Cycles allowed for the first record
    localparam int WATCHDOG_NS = 100 * (NUM_CYCLES + IDLE_CYCLES + WAIT_MAX + 20);

    logic        clk;
    logic        rst_n;
    logic        stall;
    logic        flush;
    f2_to_d_s    f2;
    bypass_s     bypass;
    reg_idx_t    rs1_idx;
    reg_idx_t    rs2_idx;
    word_t       rs1_rdata;
    word_t       rs2_rdata;
    branch_s     branch;
    d_to_e1_s    d_to_e1;

    d_to_e1_s    exp_q[$];   // One prediction per cycle
    d_to_e1_s    exp_rec;    // Expected register contents
    d_to_e1_s    prev_out;   // Output seen in the cycle before the edge
    logic        cur_stall;
    logic        cur_flush;
    int          value_errors;
    int          other_errors;
    int          wait_n;

    `include "tb_decode_model.svh"

    initial clk = 1'b0;
    always #50 clk = ~clk;

    decode_stage dut_i (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_stage_flush (flush),
        .i_stage_stall (stall),
        .i_f2_to_d     (f2),
        .o_rs1_idx     (rs1_idx),
        .o_rs2_idx     (rs2_idx),
        .i_rs1_rdata   (rs1_rdata),
        .i_rs2_rdata   (rs2_rdata),
        .i_bypass      (bypass),
        .o_branch      (branch),
        .o_d_to_e1     (d_to_e1)
    );

    // Register file stub, signed and unsigned edge values
    function automatic word_t rf_value(input reg_idx_t idx);
        word_t base;
        case (idx[2:0])
            3'd0:    base = 32'h0000_0000;
            3'd1:    base = 32'h0000_0001;
            3'd2:    base = 32'h7fff_ffff;
            3'd3:    base = 32'h8000_0000;
            3'd4:    base = 32'hffff_ffff;
            3'd5:    base = 32'h0000_0ffe;
            3'd6:    base = 32'h8000_0001;
            default: base = 32'h1234_5677; // Odd, JALR sums carry
        endcase
        return base ^ {27'h0, idx[4:3], 3'b000}; // Upper index bits too
    endfunction

    assign rs1_rdata = rf_value(rs1_idx);
    assign rs2_rdata = rf_value(rs2_idx);

    function automatic word_t bypass_value();
        word_t r;
        word_t w;
        r = $urandom;
        w = $urandom;
        return r[0] ? w : rf_value(r[5:1]);
    endfunction

    // Weighted opcode mix, about one in sixteen illegal
    function automatic word_t gen_instr();
        word_t      r;
        word_t      f;
        reg_idx_t   rs2;
        logic [4:0] bad_op;
        r   = $urandom;
        f   = $urandom;
        rs2 = (f[31:30] == 2'b00) ? f[19:15] : f[24:20]; // Equal operands now and then
        case (r[3:0])
            4'd0, 4'd1, 4'd2:
                return enc_r({1'b0, r[4], 5'b00000}, rs2, f[19:15], f[14:12], f[11:7],
                             OPCODE_OP);
            4'd3, 4'd4: return enc_i(f[31:20], f[19:15], f[14:12], f[11:7], OPCODE_OP_IMM);
            4'd5:       return enc_i(f[31:20], f[19:15], f[14:12], f[11:7], OPCODE_LOAD);
            4'd6:       return enc_s(f[31:20], rs2, f[19:15], f[14:12]);
            4'd7:       return enc_u(f[31:12], f[11:7], OPCODE_LUI);
            4'd8:       return enc_u(f[31:12], f[11:7], OPCODE_AUIPC);
            4'd9:       return enc_j(r[31:11], f[11:7]);
            4'd10:      return enc_i(f[31:20], f[19:15], 3'b000, f[11:7], OPCODE_JALR);
            4'd11, 4'd12, 4'd13:
                return enc_b(r[31:19], rs2, f[19:15], f[14:12]); // Unused funct3 included
            4'd14:      return enc_i(f[31:20], f[19:15], f[14:12], f[11:7], OPCODE_MISC_MEM);
            default: begin
                case (r[5:4])
                    2'd0:    bad_op = OPCODE_SYSTEM;
                    2'd1:    bad_op = OPCODE_AMO;
                    2'd2:    bad_op = OPCODE_OP_FP;
                    default: bad_op = 5'b11111;
                endcase
                return {f[31:7], bad_op, 2'b11};
            end
        endcase
    endfunction

    // RV32I ALU op from funct3, bit 30 picks SUB (register form) or SRA
    function automatic alu_op_e expect_alu(input logic [2:0] f3, input logic b30,
                                           input logic is_reg);
        alu_op_e op;
        case (f3)
            3'b000:  op = (is_reg && b30) ? ALU_OP_SUB : ALU_OP_ADD;
            3'b001:  op = ALU_OP_SLL;
            3'b010:  op = ALU_OP_SLT;
            3'b011:  op = ALU_OP_SLTU;
            3'b100:  op = ALU_OP_XOR;
            3'b101:  op = b30 ? ALU_OP_SRA : ALU_OP_SRL;
            3'b110:  op = ALU_OP_OR;
            default: op = ALU_OP_AND;
        endcase
        return op;
    endfunction

    // Expected record for one input, operands already bypass selected
    function automatic d_to_e1_s predict_rec(input f2_to_d_s f, input word_t rs1,
                                             input word_t rs2);
        d_to_e1_s   r;
        logic [2:0] f3;
        r           = '0;
        f3          = f.instr[14:12];
        r.valid     = f.valid;
        r.pc_word   = f.pc_word;
        r.rd_idx    = f.instr[11:7];
        r.rs1_idx   = f.instr[19:15];
        r.rs2_idx   = f.instr[24:20];
        r.rs1_rdata = rs1;
        r.rs2_rdata = rs2;
        r.immediate = model_imm(f.instr);
        case (f.instr[6:2])
            OPCODE_OP: begin
                r.rd_we  = 1'b1;
                r.alu_op = expect_alu(f3, f.instr[30], 1'b1);
            end
            OPCODE_OP_IMM: begin
                r.rd_we       = 1'b1;
                r.alu_op2_src = ALU_OP2_SRC_IMM;
                r.alu_op      = expect_alu(f3, f.instr[30], 1'b0);
            end
            OPCODE_LOAD, OPCODE_STORE: begin
                r.rd_src        = (f.instr[5]) ? RD_SRC_ALU : RD_SRC_MEM; // Bit 5 marks store
                r.rd_we         = ~f.instr[5];
                r.alu_op2_src   = ALU_OP2_SRC_IMM;
                r.memory_op     = (f.instr[5]) ? MEM_OP_STORE : MEM_OP_LOAD;
                r.memory_signed = ~f3[2];
                r.memory_size   = size_e'(f3[1:0]);
            end
            OPCODE_LUI: begin
                r.rd_we       = 1'b1;
                r.alu_op1_src = ALU_OP1_SRC_ZERO;
                r.alu_op2_src = ALU_OP2_SRC_IMM;
            end
            OPCODE_AUIPC, OPCODE_JAL: begin
                r.rd_we       = 1'b1;
                r.alu_op1_src = ALU_OP1_SRC_PC;
                r.alu_op2_src = ALU_OP2_SRC_IMM;
            end
            OPCODE_JALR: begin
                r.rd_we       = 1'b1;
                r.alu_op1_src = ALU_OP1_SRC_PC; // Link address
                r.alu_op2_src = ALU_OP2_SRC_FOUR;
            end
            OPCODE_BRANCH:   r.rd_we = 1'b0;
            OPCODE_MISC_MEM: r.fence = 1'b1;
            default:         r.illegal_instr = 1'b1; // SYSTEM and unknown
        endcase
        return r;
    endfunction

    task automatic check_val(input string name, input logic [255:0] got,
                             input logic [255:0] exp);
        assert (got === exp) else begin
            value_errors++;
            $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic drive_inputs(input logic idle);
        word_t r;
        word_t w;
        r     = $urandom;
        w     = $urandom;
        stall = 1'b0;
        flush = 1'b0;
        if (!idle) begin
            stall = (r[3:0] < 4'd2);  // Never together with flush
            flush = (r[3:0] == 4'd2);
        end
        if (!stall) begin             // Fetch holds its word while stalled
            f2.valid   = !idle && (r[6:4] != 3'd0);
            f2.pc_word = w[29:0];
            f2.instr   = gen_instr();
        end
        bypass.rs1_en   = !idle && (r[8:7] == 2'b00);
        bypass.rs2_en   = !idle && (r[10:9] == 2'b00);
        bypass.rs1_data = bypass_value();
        bypass.rs2_data = bypass_value();
    endtask

    // Mid-cycle, inputs settled
    task automatic predict_cycle();
        word_t   rs1_sel;
        word_t   rs2_sel;
        branch_s exp_br;
        logic    is_br;
        rs1_sel = bypass.rs1_en ? bypass.rs1_data : rf_value(f2.instr[19:15]);
        rs2_sel = bypass.rs2_en ? bypass.rs2_data : rf_value(f2.instr[24:20]);
        exp_br  = model_branch(f2.instr, f2.valid, f2.pc_word, rs1_sel, rs2_sel);
        is_br   = f2.instr[6:2] inside {OPCODE_BRANCH, OPCODE_JAL, OPCODE_JALR};
        check_val("o_rs1_idx", 256'(rs1_idx), 256'(f2.instr[19:15]));
        check_val("o_rs2_idx", 256'(rs2_idx), 256'(f2.instr[24:20]));
        check_val("o_branch", 256'(branch), 256'(exp_br));
        assert (!branch.taken || (f2.valid && is_br)) else begin
            other_errors++;
            $display("Branch taken at %0t without a valid branch instruction", $time);
        end
        exp_q.push_back(predict_rec(f2, rs1_sel, rs2_sel));
        prev_out = d_to_e1;
    endtask

    task automatic step(input logic idle);
        d_to_e1_s pred;
        @(posedge clk);
        pred = exp_q.pop_front();
        if (!cur_stall) begin
            exp_rec = pred;
        end
        if (cur_flush) begin
            exp_rec.valid = 1'b0;
        end
        #1;
        if (cur_stall) begin
            check_val("o_d_to_e1 (stall hold)", 256'(d_to_e1), 256'(prev_out));
        end else if (exp_rec.valid) begin
            check_val("o_d_to_e1", 256'(d_to_e1), 256'(exp_rec));
        end else begin
            check_val("o_d_to_e1.valid", 256'(d_to_e1.valid), 256'(1'b0));
        end
        drive_inputs(idle);
        cur_stall = stall;
        cur_flush = flush;
        #49;
        predict_cycle();
    endtask

    initial begin
        void'($urandom(19370));
        value_errors = 0;
        other_errors = 0;
        rst_n        = 1'b0;
        stall        = 1'b0;
        flush        = 1'b0;
        f2           = '0;
        f2.valid     = 1'b1; // Only reset keeps it out of the register
        bypass       = '0;
        cur_stall    = 1'b0;
        cur_flush    = 1'b0;
        exp_rec      = '0;
        repeat (3) @(posedge clk);
        #1;
        check_val("o_d_to_e1.valid", 256'(d_to_e1.valid), 256'(1'b0));
        rst_n = 1'b1;
        drive_inputs(1'b1);
        #49;
        predict_cycle();
        repeat (IDLE_CYCLES) step(1'b1); // Valid must stay low
        wait_n = 0;
        while (!d_to_e1.valid && wait_n < WAIT_MAX) begin
            step(1'b0);
            wait_n++;
        end
        if (!d_to_e1.valid) begin
            other_errors++;
            $display("Timeout: no valid record reached execute within %0d cycles", WAIT_MAX);
        end else begin
            repeat (NUM_CYCLES) step(1'b0);
        end
        $display("Checks done: %0d value errors, %0d other errors",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Hang guard
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: simulation ran past its time limit");
        $display("Test failed");
        $finish;
    end
endmodule : tb_decode_stage

`default_nettype wire
